//--- include/ooo_consts.svh
/* Sizing macros for the out-of-order back end
   Completion buffer depth, data width, register index width, multiplier depth */

`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// Completion buffer entries, must stay a power of two
`define OOO_CB_DEPTH 8

// Operand and result width
`define OOO_DATA_W 32

// Destination register number width
`define OOO_REG_W 5

// Multiplier pipeline depth
`define OOO_MUL_STAGES 3

`endif

//--- logic/ooo_types_pkg.sv
/* Shared types for the out-of-order back end
   Word, register index, buffer index and pointer vectors, opcode enum */

`include "ooo_consts.svh"

package ooo_types_pkg;

  // One operand or result
  typedef logic [`OOO_DATA_W-1:0] word_t;

  // Destination register number
  typedef logic [`OOO_REG_W-1:0] reg_idx_t;

  // Entry index into the completion buffer
  typedef logic [$clog2(`OOO_CB_DEPTH)-1:0] cb_idx_t;

  // Head or tail pointer, top bit is the wrap flag
  typedef logic [$clog2(`OOO_CB_DEPTH):0] cb_ptr_t;

  // Operations understood by dispatch and the units
  typedef enum logic [2:0] {
    OP_NOP  = 3'd0,
    OP_ADD  = 3'd1,
    OP_SUB  = 3'd2,
    OP_XOR  = 3'd3,
    OP_MUL  = 3'd4,
    OP_TRAP = 3'd5
  } opcode_t;

endpackage

//--- logic/dispatch_stage.sv
/* Dispatch stage, allocates the tail entry and holds one issue slot
   Routes the registered instruction to the ALU or the multiplier */

`timescale 1ns/100ps

`include "ooo_consts.svh"

module dispatch_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     in_valid,
  input  ooo_types_pkg::opcode_t   in_op,
  input  ooo_types_pkg::word_t     in_a,
  input  ooo_types_pkg::word_t     in_b,
  input  ooo_types_pkg::reg_idx_t  in_rd,
  input  logic                     full,
  input  ooo_types_pkg::cb_idx_t   cur_tail,
  input  logic                     flush,
  output logic                     alloc,
  output logic                     alu_issue,
  output logic                     mul_issue,
  output ooo_types_pkg::opcode_t   issue_op,
  output ooo_types_pkg::word_t     issue_a,
  output ooo_types_pkg::word_t     issue_b,
  output ooo_types_pkg::reg_idx_t  issue_rd,
  output ooo_types_pkg::cb_idx_t   issue_idx
);

  logic issue_valid;

  // Take the instruction only with room in the buffer, NOPs never allocate
  assign alloc = in_valid & ~full & (in_op != ooo_types_pkg::OP_NOP);

  // Issue slot occupancy, flush wins over a new allocation
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      issue_valid <= 1'b0;
    end else if (flush) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= alloc;
    end
  end

  // Instruction payload with its buffer index
  always_ff @(posedge CLK) begin
    if (alloc) begin
      issue_op  <= in_op;
      issue_a   <= in_a;
      issue_b   <= in_b;
      issue_rd  <= in_rd;
      issue_idx <= cur_tail;
    end
  end

  // Route by opcode
  assign mul_issue = issue_valid & (issue_op == ooo_types_pkg::OP_MUL);
  assign alu_issue = issue_valid & (issue_op != ooo_types_pkg::OP_MUL);

  // Only one unit receives a given instruction
  assert property (@(posedge CLK) disable iff (!nRST) !(alu_issue && mul_issue))
    else $error("alu_issue and mul_issue high together");

endmodule

//--- logic/alu_unit.sv
/* Single-cycle ALU for add, subtract, xor and trap
   Result, destination and exception flag are registered with the entry index */

`timescale 1ns/100ps

`include "ooo_consts.svh"

module alu_unit (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     alu_issue,
  input  ooo_types_pkg::opcode_t   issue_op,
  input  ooo_types_pkg::word_t     issue_a,
  input  ooo_types_pkg::word_t     issue_b,
  input  ooo_types_pkg::reg_idx_t  issue_rd,
  input  ooo_types_pkg::cb_idx_t   issue_idx,
  input  logic                     flush,
  output logic                     alu_ready,
  output ooo_types_pkg::cb_idx_t   alu_idx,
  output ooo_types_pkg::word_t     alu_data,
  output ooo_types_pkg::reg_idx_t  alu_rd,
  output logic                     alu_exc
);

  ooo_types_pkg::word_t result;

  // Trap passes operand a through as its data
  always_comb begin
    case (issue_op)
      ooo_types_pkg::OP_ADD: result = issue_a + issue_b;
      ooo_types_pkg::OP_SUB: result = issue_a - issue_b;
      ooo_types_pkg::OP_XOR: result = issue_a ^ issue_b;
      default:               result = issue_a;
    endcase
  end

  // Writeback strobe, dropped when the buffer flushes
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      alu_ready <= 1'b0;
    end else begin
      alu_ready <= alu_issue & ~flush;
    end
  end

  always_ff @(posedge CLK) begin
    if (alu_issue) begin
      alu_data <= result;
      alu_rd   <= issue_rd;
      alu_idx  <= issue_idx;
      alu_exc  <= (issue_op == ooo_types_pkg::OP_TRAP);
    end
  end

endmodule

//--- logic/mul_unit.sv
/* Pipelined multiplier, lower half of the product
   Each stage carries valid, entry index and destination; flush empties it */

`timescale 1ns/100ps

`include "ooo_consts.svh"

module mul_unit (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     mul_issue,
  input  ooo_types_pkg::word_t     issue_a,
  input  ooo_types_pkg::word_t     issue_b,
  input  ooo_types_pkg::reg_idx_t  issue_rd,
  input  ooo_types_pkg::cb_idx_t   issue_idx,
  input  logic                     flush,
  output logic                     mul_ready,
  output ooo_types_pkg::cb_idx_t   mul_idx,
  output ooo_types_pkg::word_t     mul_data,
  output ooo_types_pkg::reg_idx_t  mul_rd
);

  localparam int STAGES = `OOO_MUL_STAGES;

  logic                     vld  [STAGES];
  ooo_types_pkg::word_t     prod [STAGES];
  ooo_types_pkg::cb_idx_t   idx  [STAGES];
  ooo_types_pkg::reg_idx_t  rd   [STAGES];

  // Some stage in flight already owns the issued entry
  logic                     idx_busy;

  // Valid bits, all dropped on flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < STAGES; i++) vld[i] <= 1'b0;
    end else if (flush) begin
      for (int i = 0; i < STAGES; i++) vld[i] <= 1'b0;
    end else begin
      vld[0] <= mul_issue;
      for (int i = 1; i < STAGES; i++) vld[i] <= vld[i-1];
    end
  end

  // Product formed in the first stage, then carried down
  always_ff @(posedge CLK) begin
    prod[0] <= issue_a * issue_b;
    idx[0]  <= issue_idx;
    rd[0]   <= issue_rd;
    for (int i = 1; i < STAGES; i++) begin
      prod[i] <= prod[i-1];
      idx[i]  <= idx[i-1];
      rd[i]   <= rd[i-1];
    end
  end

  // Last stage writes back
  assign mul_ready = vld[STAGES-1];
  assign mul_data  = prod[STAGES-1];
  assign mul_idx   = idx[STAGES-1];
  assign mul_rd    = rd[STAGES-1];

  always_comb begin
    idx_busy = 1'b0;
    for (int i = 0; i < STAGES; i++) begin
      if (vld[i] && (idx[i] == issue_idx)) idx_busy = 1'b1;
    end
  end

  // Buffer entries are unique, so no two products in flight share an index
  assert property (@(posedge CLK) disable iff (!nRST) mul_issue |-> !idx_busy)
    else $error("multiply issued to an entry already in the pipeline");

endmodule

//--- logic/completion_buffer.sv
/* Completion buffer keeping program order
   Allocation at the tail, out-of-order writeback by index, in-order commit at the head
   Head entry with an exception flushes everything */

`timescale 1ns/100ps

`include "ooo_consts.svh"

module completion_buffer (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     alloc,
  input  logic                     alu_ready,
  input  ooo_types_pkg::cb_idx_t   alu_idx,
  input  ooo_types_pkg::word_t     alu_data,
  input  ooo_types_pkg::reg_idx_t  alu_rd,
  input  logic                     alu_exc,
  input  logic                     mul_ready,
  input  ooo_types_pkg::cb_idx_t   mul_idx,
  input  ooo_types_pkg::word_t     mul_data,
  input  ooo_types_pkg::reg_idx_t  mul_rd,
  output ooo_types_pkg::cb_idx_t   cur_tail,
  output logic                     full,
  output logic                     commit_valid,
  output ooo_types_pkg::reg_idx_t  commit_rd,
  output ooo_types_pkg::word_t     commit_data,
  output logic                     exception,
  output logic                     flush
);

  localparam int DEPTH = `OOO_CB_DEPTH;
  localparam int IDX_W = $clog2(DEPTH);

  // Entry storage
  ooo_types_pkg::word_t     data [DEPTH];
  ooo_types_pkg::reg_idx_t  rd   [DEPTH];
  logic                     done [DEPTH];
  logic                     exc  [DEPTH];

  ooo_types_pkg::cb_ptr_t   head;
  ooo_types_pkg::cb_ptr_t   tail;
  ooo_types_pkg::cb_idx_t   head_idx;

  // Distances used by the writeback range check
  ooo_types_pkg::cb_ptr_t   occupancy;
  ooo_types_pkg::cb_idx_t   alu_off;
  ooo_types_pkg::cb_idx_t   mul_off;

  assign head_idx = head[IDX_W-1:0];
  assign cur_tail = tail[IDX_W-1:0];

  // Same index with opposite wrap bits means every entry is taken
  assign full = (head[IDX_W-1:0] == tail[IDX_W-1:0]) && (head[IDX_W] != tail[IDX_W]);

  // Head entry drives the commit port directly
  assign commit_valid = done[head_idx] & ~exc[head_idx];
  assign exception    = done[head_idx] & exc[head_idx];
  assign flush        = exception;
  assign commit_rd    = rd[head_idx];
  assign commit_data  = data[head_idx];

  // Pointers, flush resets both and drops a same-cycle allocation
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head <= '0;
      tail <= '0;
    end else if (flush) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (commit_valid) head <= head + 1'b1;
      if (alloc)        tail <= tail + 1'b1;
    end
  end

  // Status flags per entry
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < DEPTH; i++) begin
        done[i] <= 1'b0;
        exc[i]  <= 1'b0;
      end
    end else if (flush) begin
      for (int i = 0; i < DEPTH; i++) begin
        done[i] <= 1'b0;
        exc[i]  <= 1'b0;
      end
    end else begin
      // Retired head frees its slot
      if (commit_valid) done[head_idx] <= 1'b0;
      if (alu_ready) begin
        done[alu_idx] <= 1'b1;
        exc[alu_idx]  <= alu_exc;
      end
      // Multiplier never raises an exception
      if (mul_ready) begin
        done[mul_idx] <= 1'b1;
        exc[mul_idx]  <= 1'b0;
      end
    end
  end

  // Result payload, both units may land in one cycle on different entries
  always_ff @(posedge CLK) begin
    if (alu_ready) begin
      data[alu_idx] <= alu_data;
      rd[alu_idx]   <= alu_rd;
    end
    if (mul_ready) begin
      data[mul_idx] <= mul_data;
      rd[mul_idx]   <= mul_rd;
    end
  end

  assign occupancy = tail - head;
  assign alu_off   = alu_idx - head_idx;
  assign mul_off   = mul_idx - head_idx;

  // Dispatch must respect back-pressure
  assert property (@(posedge CLK) disable iff (!nRST) !(alloc && full))
    else $error("alloc while the buffer is full");

  // Writebacks land only on allocated entries
  assert property (@(posedge CLK) disable iff (!nRST)
                   alu_ready |-> ({1'b0, alu_off} < occupancy))
    else $error("ALU writeback outside head to tail");
  assert property (@(posedge CLK) disable iff (!nRST)
                   mul_ready |-> ({1'b0, mul_off} < occupancy))
    else $error("multiplier writeback outside head to tail");

endmodule

//--- logic/ooo_core.sv
/* Top level of the out-of-order back end
   Dispatch, ALU, multiplier and completion buffer wired together */

`timescale 1ns/100ps

`include "ooo_consts.svh"

module ooo_core (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     in_valid,
  input  ooo_types_pkg::opcode_t   in_op,
  input  ooo_types_pkg::word_t     in_a,
  input  ooo_types_pkg::word_t     in_b,
  input  ooo_types_pkg::reg_idx_t  in_rd,
  output logic                     full,
  output logic                     commit_valid,
  output ooo_types_pkg::reg_idx_t  commit_rd,
  output ooo_types_pkg::word_t     commit_data,
  output logic                     exception
);

  // Dispatch and issue
  logic                     alloc;
  logic                     flush;
  ooo_types_pkg::cb_idx_t   cur_tail;
  logic                     alu_issue;
  logic                     mul_issue;
  ooo_types_pkg::opcode_t   issue_op;
  ooo_types_pkg::word_t     issue_a;
  ooo_types_pkg::word_t     issue_b;
  ooo_types_pkg::reg_idx_t  issue_rd;
  ooo_types_pkg::cb_idx_t   issue_idx;

  // Writeback buses
  logic                     alu_ready;
  ooo_types_pkg::cb_idx_t   alu_idx;
  ooo_types_pkg::word_t     alu_data;
  ooo_types_pkg::reg_idx_t  alu_rd;
  logic                     alu_exc;
  logic                     mul_ready;
  ooo_types_pkg::cb_idx_t   mul_idx;
  ooo_types_pkg::word_t     mul_data;
  ooo_types_pkg::reg_idx_t  mul_rd;

  dispatch_stage u_dispatch (
    .CLK(CLK), .nRST(nRST),
    .in_valid(in_valid), .in_op(in_op), .in_a(in_a), .in_b(in_b), .in_rd(in_rd),
    .full(full), .cur_tail(cur_tail), .flush(flush), .alloc(alloc),
    .alu_issue(alu_issue), .mul_issue(mul_issue), .issue_op(issue_op),
    .issue_a(issue_a), .issue_b(issue_b), .issue_rd(issue_rd), .issue_idx(issue_idx)
  );

  alu_unit u_alu (
    .CLK(CLK), .nRST(nRST),
    .alu_issue(alu_issue), .issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b),
    .issue_rd(issue_rd), .issue_idx(issue_idx), .flush(flush),
    .alu_ready(alu_ready), .alu_idx(alu_idx), .alu_data(alu_data),
    .alu_rd(alu_rd), .alu_exc(alu_exc)
  );

  mul_unit u_mul (
    .CLK(CLK), .nRST(nRST),
    .mul_issue(mul_issue), .issue_a(issue_a), .issue_b(issue_b),
    .issue_rd(issue_rd), .issue_idx(issue_idx), .flush(flush),
    .mul_ready(mul_ready), .mul_idx(mul_idx), .mul_data(mul_data), .mul_rd(mul_rd)
  );

  completion_buffer u_cb (
    .CLK(CLK), .nRST(nRST), .alloc(alloc),
    .alu_ready(alu_ready), .alu_idx(alu_idx), .alu_data(alu_data),
    .alu_rd(alu_rd), .alu_exc(alu_exc),
    .mul_ready(mul_ready), .mul_idx(mul_idx), .mul_data(mul_data), .mul_rd(mul_rd),
    .cur_tail(cur_tail), .full(full),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data),
    .exception(exception), .flush(flush)
  );

endmodule

//--- tests/tb_clock.sv
/* Testbench clock and reset source
   4 ns clock, reset held low for 16 cycles */

`timescale 1ns/100ps

module tb_clock (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Release on a rising edge after 16 cycles
  initial begin
    nRST = 1'b0;
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;
  end

endmodule

//--- tests/ooo_core_tb.sv
/* Testbench for the out-of-order back end
   LCG stimulus, reference results, in-order commit model, timeout and summary */

`timescale 1ns/100ps

`include "ooo_consts.svh"

module ooo_core_tb;

  localparam int DEPTH = `OOO_CB_DEPTH;

  // Instructions per test
  localparam int N_ALU         = 24;
  localparam int N_MIX         = 33;
  localparam int N_MULS        = 40;
  localparam int N_TRAP_ROUNDS = 6;
  localparam int N_NOP         = 24;
  localparam int N_RANDOM      = 131;
  localparam int N_TOTAL = N_ALU + N_MIX + N_MULS + 8 * N_TRAP_ROUNDS + N_NOP + N_RANDOM;
  // Ten cycles per instruction, plus room for reset and drains
  localparam int MAX_CYCLES = 10 * N_TOTAL + 1000;

  logic                     CLK;
  logic                     nRST;
  logic                     in_valid;
  ooo_types_pkg::opcode_t   in_op;
  ooo_types_pkg::word_t     in_a;
  ooo_types_pkg::word_t     in_b;
  ooo_types_pkg::reg_idx_t  in_rd;
  logic                     full;
  logic                     commit_valid;
  ooo_types_pkg::reg_idx_t  commit_rd;
  ooo_types_pkg::word_t     commit_data;
  logic                     exception;

  // Expected commits, oldest first
  ooo_types_pkg::reg_idx_t  exp_rd   [$];
  ooo_types_pkg::word_t     exp_data [$];
  bit                       exp_trap [$];

  // Occupancy model and run counters
  int occ        = 0;
  int peak       = 0;
  int errors     = 0;
  int commits    = 0;
  int exceptions = 0;
  int dropped    = 0;
  int cycles     = 0;
  logic [31:0] lcg_state = 32'd98;

  tb_clock u_clock (.CLK(CLK), .nRST(nRST));

  ooo_core DUT (
    .CLK(CLK), .nRST(nRST),
    .in_valid(in_valid), .in_op(in_op), .in_a(in_a), .in_b(in_b), .in_rd(in_rd),
    .full(full), .commit_valid(commit_valid), .commit_rd(commit_rd),
    .commit_data(commit_data), .exception(exception)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper LCG bits pick the op, low bits are weak
  function automatic ooo_types_pkg::opcode_t alu_op(input logic [31:0] r);
    case (r[31:30])
      2'd0:    return ooo_types_pkg::OP_ADD;
      2'd1:    return ooo_types_pkg::OP_SUB;
      default: return ooo_types_pkg::OP_XOR;
    endcase
  endfunction

  // NOP and trap rare, multiply about a third
  function automatic ooo_types_pkg::opcode_t any_op(input logic [31:0] r);
    case (r[31:28])
      4'd0:                         return ooo_types_pkg::OP_NOP;
      4'd1:                         return ooo_types_pkg::OP_TRAP;
      4'd2, 4'd3, 4'd4, 4'd5, 4'd6: return ooo_types_pkg::OP_MUL;
      default:                      return alu_op(r << 4);
    endcase
  endfunction

  // Reference result per op, products keep the lower word
  function automatic ooo_types_pkg::word_t expected_result(input ooo_types_pkg::opcode_t op,
      input ooo_types_pkg::word_t a, input ooo_types_pkg::word_t b);
    case (op)
      ooo_types_pkg::OP_ADD: return a + b;
      ooo_types_pkg::OP_SUB: return a - b;
      ooo_types_pkg::OP_XOR: return a ^ b;
      ooo_types_pkg::OP_MUL: return a * b;
      default:               return a;
    endcase
  endfunction

  task automatic compare_head(input ooo_types_pkg::reg_idx_t rd, input ooo_types_pkg::word_t data);
    if (commit_rd !== rd) begin
      $display("ERROR commit_rd: got %h expected %h", commit_rd, rd);
      errors++;
    end
    if (commit_data !== data) begin
      $display("ERROR commit_data: got %h expected %h", commit_data, data);
      errors++;
    end
  endtask

  task automatic report_counts();
    $display("Errors %0d, commits %0d, exceptions %0d, dropped %0d, peak occupancy %0d",
             errors, commits, exceptions, dropped, peak);
  endtask

  // Commit checker, runs on pre-edge values
  always @(posedge CLK) begin : compare
    logic accept;
    accept = in_valid && (in_op != ooo_types_pkg::OP_NOP) && (occ < DEPTH);
    if (nRST) begin
      if (full !== (occ == DEPTH)) begin
        $display("ERROR full: got %h expected %h", full, occ == DEPTH);
        errors++;
      end
      if (exception) begin
        if (exp_rd.size() == 0) begin
          $display("Exception raised while no instruction was outstanding");
          errors++;
        end else begin
          if (!exp_trap[0]) begin
            $display("Exception raised by a head entry that is not a trap");
            errors++;
          end
          compare_head(exp_rd[0], exp_data[0]);
          dropped += exp_rd.size() - 1;
        end
        // Whole buffer flushed, same-edge allocation included
        exceptions++;
        exp_rd.delete();
        exp_data.delete();
        exp_trap.delete();
        occ = 0;
      end else begin
        if (commit_valid) begin
          if (exp_rd.size() == 0) begin
            $display("Commit seen with no instruction outstanding");
            errors++;
          end else begin
            if (exp_trap[0]) begin
              $display("Trap retired as a normal commit instead of an exception");
              errors++;
            end
            compare_head(exp_rd[0], exp_data[0]);
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
            void'(exp_trap.pop_front());
            occ--;
          end
          commits++;
        end
        if (accept) begin
          exp_rd.push_back(in_rd);
          exp_data.push_back(expected_result(in_op, in_a, in_b));
          exp_trap.push_back(in_op == ooo_types_pkg::OP_TRAP);
          occ++;
          if (occ > peak) peak = occ;
        end
      end
    end
  end

  // Drive one instruction for one cycle, never into a full buffer
  task automatic send(input ooo_types_pkg::opcode_t op, input ooo_types_pkg::word_t a,
      input ooo_types_pkg::word_t b, input ooo_types_pkg::reg_idx_t rd);
    int nxt;
    nxt = DEPTH;
    while (nxt >= DEPTH) begin
      // Occupancy after the coming edge
      @(negedge CLK);
      if (exception) nxt = 0;
      else nxt = occ + int'(in_valid && in_op != ooo_types_pkg::OP_NOP) - int'(commit_valid);
      @(posedge CLK);
      if (nxt >= DEPTH) in_valid <= 1'b0;
    end
    in_valid <= 1'b1;
    in_op    <= op;
    in_a     <= a;
    in_b     <= b;
    in_rd    <= rd;
  endtask

  task automatic send_random(input ooo_types_pkg::opcode_t op);
    ooo_types_pkg::word_t a;
    ooo_types_pkg::word_t b;
    logic [31:0] r;
    a = next_random();
    b = next_random();
    r = next_random();
    send(op, a, b, r[31:27]);
  endtask

  // Drop in_valid and wait until every expected commit arrived
  task automatic drain();
    @(posedge CLK);
    in_valid <= 1'b0;
    do @(negedge CLK); while (exp_rd.size() != 0);
    repeat (3) @(posedge CLK);
  endtask

  initial begin : stimulus
    in_valid = 1'b0;
    in_op    = ooo_types_pkg::OP_NOP;
    in_a     = '0;
    in_b     = '0;
    in_rd    = '0;
    wait (nRST === 1'b1);
    @(posedge CLK);

    // Back-to-back ALU ops
    for (int i = 0; i < N_ALU; i++) send_random(alu_op(next_random()));
    drain();

    // Each multiply followed by two faster ALU ops
    for (int i = 0; i < N_MIX; i++)
      send_random(i % 3 == 0 ? ooo_types_pkg::OP_MUL : alu_op(next_random()));
    drain();

    // Multiply stream keeps the buffer busy
    for (int i = 0; i < N_MULS; i++) send_random(ooo_types_pkg::OP_MUL);
    drain();

    // Trap after a short prefix, younger ops flushed behind it
    for (int k = 0; k < N_TRAP_ROUNDS; k++) begin
      for (int i = 0; i < 1 + k % 4; i++)
        send_random(i % 2 == 0 ? ooo_types_pkg::OP_MUL : ooo_types_pkg::OP_ADD);
      send_random(ooo_types_pkg::OP_TRAP);
      for (int i = 0; i < 6 - k % 4; i++) send_random(alu_op(next_random()));
      drain();
    end
    if (exceptions != N_TRAP_ROUNDS) begin
      $display("Trap rounds raised %0d exceptions instead of %0d", exceptions, N_TRAP_ROUNDS);
      errors++;
    end

    // NOPs between ALU ops
    for (int i = 0; i < N_NOP; i++)
      send_random(i % 2 == 0 ? ooo_types_pkg::OP_NOP : alu_op(next_random()));
    drain();

    // Long mix of every opcode
    for (int i = 0; i < N_RANDOM; i++) send_random(any_op(next_random()));
    drain();

    report_counts();
    if (errors == 0) $display("PASS: all tests");
    else $display("FAIL: see errors above");
    $finish;
  end

  initial begin : watchdog
    while (cycles < MAX_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles, %0d commits still expected",
             MAX_CYCLES, exp_rd.size());
    report_counts();
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
logic/ooo_types_pkg.sv
logic/dispatch_stage.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/completion_buffer.sv
logic/ooo_core.sv
tests/tb_clock.sv
tests/ooo_core_tb.sv

//--- Makefile
# Verilator build and run for the out-of-order back end
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := ooo_core_tb
FILELIST := vlog.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(wildcard logic/*.sv tests/*.sv include/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(OBJDIR)/V%: $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
